/* logic/color_overlay.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Colour overlay
// Tints the monochrome video by brick row and registers the
// colour together with horizontal and vertical blanking
////////////////////////////////////////////////////////////
module color_overlay (
  input  logic             clk_sys,
  input  logic             rst_n,
  input  logic             video,
  input  logic             cocktail,
  input  logic             player2,
  input  logic [7:0]       hcnt,
  input  logic [7:0]       vcnt,
  output paddle_pkg::rgb_t rgb,
  output logic             hblank,
  output logic             vblank
);
  import paddle_pkg::*;

  logic [4:0] band_hit;
  logic       hblank_p1;
  logic       hblank_p2;
  rgb_t       rgb_next;

  function automatic logic in_band(input logic [7:0] v, input logic [7:0] lo,
                                   input logic [7:0] hi);
    return (v >= lo) && (v <= hi);
  endfunction

  // Bands 0 to 3 are the brick rows
  // Player 2 rows show only on a cocktail cabinet
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      band_hit[i] = in_band(hcnt, ROW_P1_LO[i], ROW_P1_LO[i] + ROW_SPAN) ||
                    (cocktail && in_band(hcnt, ROW_P2_LO[i], ROW_P2_LO[i] + ROW_SPAN));
    end
    // Band 4 is the blue strip of the upright cabinet
    band_hit[4] = !cocktail && in_band(hcnt, BLUE_LO, BLUE_HI);
  end

  // Lowest band index has priority
  // White outside all bands, black without video
  always_comb begin
    rgb_next = COL_WHITE;
    for (int i = 4; i >= 0; i--) begin
      if (band_hit[i]) begin
        rgb_next = BAND_COLOR[i];
      end
    end
    if (!video) begin
      rgb_next = COL_BLACK;
    end
  end

  assign hblank_p1 = (hcnt >= HBLANK_P1_GE) || (hcnt <= HBLANK_P1_LE);
  assign hblank_p2 = (hcnt >= HBLANK_P2_GE) || (hcnt <= HBLANK_P2_LE);

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      rgb    <= COL_BLACK;
      hblank <= 1'b0;
      vblank <= 1'b0;
    end else begin
      rgb    <= rgb_next;
      // Screen is flipped for player 2 on a cocktail cabinet
      hblank <= (cocktail && player2) ? hblank_p2 : hblank_p1;
      vblank <= (vcnt >= VBLANK_LO) && (vcnt <= VBLANK_HI);
    end
  end

endmodule

/* logic/digital_paddle.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Digital paddle tracker
// Steps the pad once per frame from the active player's
// left and right buttons, clamped to the position range
////////////////////////////////////////////////////////////
module digital_paddle #(
  parameter int POS_W = paddle_pkg::POS_W
) (
  input  logic             clk_sys,
  input  logic             rst_n,
  input  logic             p1_right,
  input  logic             p1_left,
  input  logic             p2_right,
  input  logic             p2_left,
  input  logic             player2,
  input  logic             digital_fast,
  input  logic             vsync,
  output logic [POS_W-1:0] pos_digital
);
  import paddle_pkg::*;

  localparam int SUM_W = POS_W + 1;

  logic             vsync_d;
  logic             frame_tick;
  logic             right;
  logic             left;
  logic [SUM_W-1:0] step;
  logic [SUM_W-1:0] pos_up;
  logic [SUM_W-1:0] pos_dn;

  // Buttons of the player at the controls
  assign right = player2 ? p2_right : p1_right;
  assign left  = player2 ? p2_left : p1_left;
  assign step  = digital_fast ? SUM_W'(STEP_FAST) : SUM_W'(STEP_SLOW);

  // Top bit flags a result past max or below zero
  assign pos_up = {1'b0, pos_digital} + step;
  assign pos_dn = {1'b0, pos_digital} - step;

  always_ff @(posedge clk_sys) begin
    // Previous vsync level
    vsync_d <= vsync;
    if (!rst_n) begin
      frame_tick  <= 1'b0;
      pos_digital <= POS_W'(POS_CENTER);
    end else begin
      // One pulse per frame on the vsync rising edge
      frame_tick <= vsync & ~vsync_d;
      // Left is tested first and wins when both are held
      if (frame_tick && left) begin
        pos_digital <= pos_up[POS_W] ? {POS_W{1'b1}} : pos_up[POS_W-1:0];
      end else if (frame_tick && right) begin
        pos_digital <= pos_dn[POS_W] ? '0 : pos_dn[POS_W-1:0];
      end
    end
  end

endmodule

/* logic/pad_beam_compare.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Pad beam comparator
// Counts lines from pad enable and draws the pad while the
// count is below the pad position
////////////////////////////////////////////////////////////
module pad_beam_compare #(
  parameter int POS_W = paddle_pkg::POS_W
) (
  input  logic             clk_sys,
  input  logic             rst_n,
  input  logic             hsync,
  input  logic             pad_en_n,
  input  logic [POS_W-1:0] pad_pos,
  output logic             pad_out
);

  logic             hsync_d;
  logic             line_tick;
  logic             pad_en_q;
  logic [POS_W-1:0] line_cnt;

  always_ff @(posedge clk_sys) begin
    hsync_d <= hsync;
    if (!rst_n) begin
      line_tick <= 1'b0;
      pad_en_q  <= 1'b0;
      line_cnt  <= '0;
    end else begin
      // Registered hsync rising edge and pad enable
      line_tick <= hsync & ~hsync_d;
      pad_en_q  <= ~pad_en_n;
      // Pad enable restarts the count ahead of the pad area
      if (pad_en_q) begin
        line_cnt <= '0;
      end else if (line_tick) begin
        line_cnt <= line_cnt + 1'b1;
      end
    end
  end

  // Pad drawn on lines before the selected position
  assign pad_out = line_cnt < pad_pos;

endmodule

/* logic/paddle_pkg.sv */
////////////////////////////////////////////////////////////
// Paddle video definitions
// Position width, control and spinner modes, brick row and
// blanking bounds, overlay colours
////////////////////////////////////////////////////////////
package paddle_pkg;

  // Position width and reset position
  localparam int POS_W      = 8;
  localparam int POS_CENTER = 128;

  // Per-player control mode
  // Codes 5 to 7 select the centre position
  typedef enum logic [2:0] {
    MODE_DIGITAL = 3'd0,
    MODE_STICK_X = 3'd1,
    MODE_STICK_Y = 3'd2,
    MODE_KNOB    = 3'd3,
    MODE_SPINNER = 3'd4
  } ctrl_mode_e;

  // Digital steps per frame
  localparam int STEP_SLOW = 4;
  localparam int STEP_FAST = 8;

  // Spinner magnitude scaling
  typedef enum logic [1:0] {
    SPIN_SHL1     = 2'd0,
    SPIN_SHL2     = 2'd1,
    SPIN_SHL3     = 2'd2,
    SPIN_UNSCALED = 2'd3
  } spin_speed_e;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  ////////////////////////////////////////////////////////////
  // Overlay bands by hcnt
  ////////////////////////////////////////////////////////////
  // Brick rows in order red, amber, green, yellow
  // Each row covers its start value and the next 7
  localparam logic [7:0] ROW_P1_LO [4] = '{8'd64, 8'd72, 8'd80, 8'd88};
  localparam logic [7:0] ROW_P2_LO [4] = '{8'd184, 8'd176, 8'd168, 8'd160};
  localparam logic [7:0] ROW_SPAN      = 8'd7;
  // Blue strip, upright cabinet only
  localparam logic [7:0] BLUE_LO = 8'd211;
  localparam logic [7:0] BLUE_HI = 8'd219;

  // Horizontal blanking at or above GE and at or below LE
  localparam logic [7:0] HBLANK_P1_GE = 8'd224;
  localparam logic [7:0] HBLANK_P1_LE = 8'd24;
  localparam logic [7:0] HBLANK_P2_GE = 8'd232;
  localparam logic [7:0] HBLANK_P2_LE = 8'd32;
  // Vertical blanking window, inclusive
  localparam logic [7:0] VBLANK_LO = 8'd228;
  localparam logic [7:0] VBLANK_HI = 8'd251;

  // Band colours red, amber, green, yellow, blue
  localparam rgb_t BAND_COLOR [5] = '{12'hA21, 12'hC81, 12'h173, 12'hCC3, 12'h17C};
  localparam rgb_t COL_WHITE = 12'hFFF;
  localparam rgb_t COL_BLACK = 12'h000;

endpackage

/* logic/paddle_select.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Paddle source selector
// Picks the active player's control mode and registers the
// resulting pad position
////////////////////////////////////////////////////////////
module paddle_select #(
  parameter int POS_W = paddle_pkg::POS_W
) (
  input  logic                   clk_sys,
  input  logic                   rst_n,
  input  paddle_pkg::ctrl_mode_e p1_mode,
  input  paddle_pkg::ctrl_mode_e p2_mode,
  input  logic                   p1_invert,
  input  logic                   p2_invert,
  input  logic                   player2,
  input  logic [7:0]             p1_stick_x,
  input  logic [7:0]             p1_stick_y,
  input  logic [7:0]             p2_stick_x,
  input  logic [7:0]             p2_stick_y,
  input  logic [7:0]             p1_knob,
  input  logic [7:0]             p2_knob,
  input  logic [POS_W-1:0]       pos_digital,
  input  logic [POS_W-1:0]       pos_spin,
  output logic [POS_W-1:0]       pad_pos
);
  import paddle_pkg::*;

  ctrl_mode_e       mode;
  logic             invert;
  logic [7:0]       stick_x;
  logic [7:0]       stick_y;
  logic [7:0]       analog;
  logic [POS_W-1:0] pos_next;

  assign mode   = player2 ? p2_mode : p1_mode;
  assign invert = player2 ? p2_invert : p1_invert;
  // Two's complement stick to offset binary
  assign stick_x = player2 ? {~p2_stick_x[7], p2_stick_x[6:0]} : {~p1_stick_x[7], p1_stick_x[6:0]};
  assign stick_y = player2 ? {~p2_stick_y[7], p2_stick_y[6:0]} : {~p1_stick_y[7], p1_stick_y[6:0]};

  always_comb begin
    case (mode)
      MODE_STICK_X: analog = stick_x;
      MODE_STICK_Y: analog = stick_y;
      default:      analog = player2 ? p2_knob : p1_knob;
    endcase
  end

  // Analog sources run opposite to the pad unless inverted
  always_comb begin
    case (mode)
      MODE_DIGITAL: pos_next = pos_digital;
      MODE_STICK_X, MODE_STICK_Y, MODE_KNOB: pos_next = POS_W'(invert ? analog : ~analog);
      MODE_SPINNER: pos_next = pos_spin;
      default:      pos_next = POS_W'(POS_CENTER);
    endcase
  end

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      pad_pos <= POS_W'(POS_CENTER);
    end else begin
      pad_pos <= pos_next;
    end
  end

endmodule

/* logic/paddle_video_top.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Paddle control and colour overlay top level
// Position trackers feed the selector, whose registered pad
// position drives the beam comparator
////////////////////////////////////////////////////////////
module paddle_video_top #(
  parameter int POS_W = paddle_pkg::POS_W
) (
  input  logic                    clk_sys,
  input  logic                    rst_n,
  input  logic                    p1_joy_right,
  input  logic                    p1_joy_left,
  input  logic                    p2_joy_right,
  input  logic                    p2_joy_left,
  input  logic [8:0]              p1_spinner,
  input  logic [8:0]              p2_spinner,
  input  logic [7:0]              p1_stick_x,
  input  logic [7:0]              p1_stick_y,
  input  logic [7:0]              p2_stick_x,
  input  logic [7:0]              p2_stick_y,
  input  logic [7:0]              p1_knob,
  input  logic [7:0]              p2_knob,
  input  paddle_pkg::ctrl_mode_e  p1_mode,
  input  paddle_pkg::ctrl_mode_e  p2_mode,
  input  logic                    p1_invert,
  input  logic                    p2_invert,
  input  logic                    digital_fast,
  input  paddle_pkg::spin_speed_e spin_speed,
  input  logic                    player2,
  input  logic                    cocktail,
  input  logic                    hsync,
  input  logic                    vsync,
  input  logic                    pad_en_n,
  input  logic                    video,
  input  logic [7:0]              hcnt,
  input  logic [7:0]              vcnt,
  output logic                    pad_out,
  output paddle_pkg::rgb_t        rgb,
  output logic                    hblank,
  output logic                    vblank
);

  logic [POS_W-1:0] pos_digital;
  logic [POS_W-1:0] pos_spin;
  logic [POS_W-1:0] pad_pos;

  // Position producers
  digital_paddle #(.POS_W(POS_W)) u_digital (
    .clk_sys, .rst_n,
    .p1_right(p1_joy_right), .p1_left(p1_joy_left),
    .p2_right(p2_joy_right), .p2_left(p2_joy_left),
    .player2, .digital_fast, .vsync, .pos_digital
  );

  spinner_paddle #(.POS_W(POS_W)) u_spinner (
    .clk_sys, .rst_n,
    .spinner_p1(p1_spinner), .spinner_p2(p2_spinner),
    .player2, .p1_invert, .p2_invert, .spin_speed, .pos_spin
  );

  // Registered pad position
  paddle_select #(.POS_W(POS_W)) u_select (
    .clk_sys, .rst_n, .p1_mode, .p2_mode, .p1_invert, .p2_invert, .player2,
    .p1_stick_x, .p1_stick_y, .p2_stick_x, .p2_stick_y, .p1_knob, .p2_knob,
    .pos_digital, .pos_spin, .pad_pos
  );

  // Consumers on the video side
  pad_beam_compare #(.POS_W(POS_W)) u_beam (
    .clk_sys, .rst_n, .hsync, .pad_en_n, .pad_pos, .pad_out
  );

  color_overlay u_overlay (
    .clk_sys, .rst_n, .video, .cocktail, .player2,
    .hcnt, .vcnt, .rgb, .hblank, .vblank
  );

endmodule

/* logic/spinner_paddle.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Spinner paddle tracker
// Accumulates signed spinner increments on each tick of the
// active spinner, scaled by speed and clamped to range
////////////////////////////////////////////////////////////
module spinner_paddle #(
  parameter int POS_W = paddle_pkg::POS_W
) (
  input  logic                    clk_sys,
  input  logic                    rst_n,
  input  logic [8:0]              spinner_p1,
  input  logic [8:0]              spinner_p2,
  input  logic                    player2,
  input  logic                    p1_invert,
  input  logic                    p2_invert,
  input  paddle_pkg::spin_speed_e spin_speed,
  output logic [POS_W-1:0]        pos_spin
);
  import paddle_pkg::*;

  // Room for a 10-bit scaled step plus a carry
  localparam int SUM_W = ((POS_W > 10) ? POS_W : 10) + 1;
  localparam logic [SUM_W-1:0] POS_MAX = SUM_W'({POS_W{1'b1}});

  logic             sp1_msb_d;
  logic             sp2_msb_d;
  logic [7:0]       spin;
  logic             tick;
  logic [6:0]       mag;
  logic [9:0]       step;
  logic             tick_q;
  logic             add_q;
  logic [9:0]       step_q;
  logic [SUM_W-1:0] pos_ext;
  logic [SUM_W-1:0] pos_up;

  ////////////////////////////////////////////////////////////
  // Tick detection and step scaling
  ////////////////////////////////////////////////////////////
  assign spin = player2 ? spinner_p2[7:0] : spinner_p1[7:0];
  // Only a bit 8 toggle of the active spinner counts
  assign tick = player2 ? (spinner_p2[8] ^ sp2_msb_d) : (spinner_p1[8] ^ sp1_msb_d);
  // Absolute value of the signed low byte with 7 bits kept
  assign mag  = spin[7] ? (~spin[6:0] + 7'd1) : spin[6:0];

  always_comb begin
    case (spin_speed)
      SPIN_SHL1:     step = {3'b000, mag} << 1;
      SPIN_SHL2:     step = {3'b000, mag} << 2;
      SPIN_SHL3:     step = {3'b000, mag} << 3;
      SPIN_UNSCALED: step = {3'b000, mag};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Clamped accumulation
  ////////////////////////////////////////////////////////////
  assign pos_ext = SUM_W'(pos_spin);
  assign pos_up  = pos_ext + SUM_W'(step_q);

  always_ff @(posedge clk_sys) begin
    sp1_msb_d <= spinner_p1[8];
    sp2_msb_d <= spinner_p2[8];
    // Direction after per-player inversion where 1 adds
    add_q     <= spin[7] ^ (player2 ? p2_invert : p1_invert);
    step_q    <= step;
    if (!rst_n) begin
      tick_q   <= 1'b0;
      pos_spin <= POS_W'(POS_CENTER);
    end else begin
      tick_q <= tick;
      if (tick_q && add_q) begin
        pos_spin <= (pos_up > POS_MAX) ? POS_MAX[POS_W-1:0] : pos_up[POS_W-1:0];
      end else if (tick_q) begin
        pos_spin <= (SUM_W'(step_q) > pos_ext) ? '0 : POS_W'(pos_ext - SUM_W'(step_q));
      end
    end
  end

endmodule

/* paddle_video_top.f */
logic/paddle_pkg.sv
logic/digital_paddle.sv
logic/spinner_paddle.sv
logic/paddle_select.sv
logic/pad_beam_compare.sv
logic/color_overlay.sv
logic/paddle_video_top.sv
verification/tb_clock_gen.sv
verification/paddle_video_tb.sv

/* verification/paddle_video_tb.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Paddle video testbench
// Directed tests of the digital, spinner and analog pad
// modes, the pad raster comparison and the colour overlay
////////////////////////////////////////////////////////////
module paddle_video_tb;
  import paddle_pkg::*;

  localparam int LINE_LIMIT  = 256;
  localparam int RESET_LIMIT = 20;

  logic        clk_sys;
  logic        rst_n;
  logic        p1_joy_right;
  logic        p1_joy_left;
  logic        p2_joy_right;
  logic        p2_joy_left;
  logic [8:0]  p1_spinner;
  logic [8:0]  p2_spinner;
  logic [7:0]  p1_stick_x;
  logic [7:0]  p1_stick_y;
  logic [7:0]  p2_stick_x;
  logic [7:0]  p2_stick_y;
  logic [7:0]  p1_knob;
  logic [7:0]  p2_knob;
  ctrl_mode_e  p1_mode;
  ctrl_mode_e  p2_mode;
  logic        p1_invert;
  logic        p2_invert;
  logic        digital_fast;
  spin_speed_e spin_speed;
  logic        player2;
  logic        cocktail;
  logic        hsync;
  logic        vsync;
  logic        pad_en_n;
  logic        video;
  logic [7:0]  hcnt;
  logic [7:0]  vcnt;
  logic        pad_out;
  rgb_t        rgb;
  logic        hblank;
  logic        vblank;

  int seed = 88680;
  int err_cnt = 0;
  int test_cnt = 0;
  int bad_test_cnt = 0;
  // Reference positions carried between tests
  int digital_pos = 128;
  int spin_pos = 128;

  tb_clock_gen u_clk (.clk_sys, .rst_n);

  paddle_video_top #(.POS_W(8)) DUT (.*);

  ////////////////////////////////////////////////////////////
  // Checking and reporting
  ////////////////////////////////////////////////////////////
  task automatic check_value(input int got, input int exp, input string what);
    assert (got == exp) else begin
      $display("FAIL at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic abort_wait(input string what);
    $display("Timed out at %0d ns waiting for %s", $time, what);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d failed checks", name, err_cnt - errs_before);
      bad_test_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////
  function automatic int clamp_pos(input int pos);
    return (pos > 255) ? 255 : ((pos < 0) ? 0 : pos);
  endfunction

  // Left adds, right subtracts, left wins on both
  function automatic int digital_model(input int pos, input bit left, input bit right,
                                       input bit fast);
    int step;
    step = fast ? 8 : 4;
    if (left) begin
      return clamp_pos(pos + step);
    end
    return right ? clamp_pos(pos - step) : pos;
  endfunction

  function automatic int spinner_model(input int pos, input logic [7:0] low,
                                       input logic [1:0] spd, input bit inv);
    int mag;
    int step;
    // Absolute value of the signed byte kept to 7 bits
    mag = low[7] ? 256 - low : low;
    mag = mag % 128;
    step = (spd == 2'd3) ? mag : mag << (spd + 1);
    return (low[7] ^ inv) ? clamp_pos(pos + step) : clamp_pos(pos - step);
  endfunction

  function automatic logic [11:0] expected_color(input int h, input bit ck);
    return ((h >= 64 && h <= 71) || (ck && h >= 184 && h <= 191)) ? 12'hA21 :
           ((h >= 72 && h <= 79) || (ck && h >= 176 && h <= 183)) ? 12'hC81 :
           ((h >= 80 && h <= 87) || (ck && h >= 168 && h <= 175)) ? 12'h173 :
           ((h >= 88 && h <= 95) || (ck && h >= 160 && h <= 167)) ? 12'hCC3 :
           (!ck && h >= 211 && h <= 219) ? 12'h17C : 12'hFFF;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  // One vsync pulse and time for the pad position to settle
  task automatic pulse_frame();
    @(posedge clk_sys);
    vsync <= 1'b1;
    @(posedge clk_sys);
    vsync <= 1'b0;
    repeat (3) @(posedge clk_sys);
  endtask

  // Pad enable pulse that leaves the line count at 0
  task automatic start_pad_frame();
    @(posedge clk_sys);
    pad_en_n <= 1'b0;
    @(posedge clk_sys);
    pad_en_n <= 1'b1;
    @(posedge clk_sys);
    @(negedge clk_sys);
  endtask

  // One hsync pulse and a wait until the count has moved on
  task automatic issue_line();
    @(posedge clk_sys);
    hsync <= 1'b1;
    @(posedge clk_sys);
    hsync <= 1'b0;
    @(posedge clk_sys);
    @(negedge clk_sys);
  endtask

  // Lines with pad_out high from pad enable until it drops
  task automatic expect_boundary(input int exp, input string what);
    int n;
    start_pad_frame();
    n = 0;
    while (pad_out && n < LINE_LIMIT) begin
      issue_line();
      n++;
    end
    if (pad_out) begin
      abort_wait("pad_out to drop");
    end else begin
      check_value(n, exp, what);
      // Pad must stay off for the rest of the frame
      while (n < LINE_LIMIT - 1) begin
        issue_line();
        n++;
        assert (!pad_out) else begin
          $display("FAIL at %0d ns: pad_out high again on line %0d", $time, n);
          err_cnt++;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset_digital();
    int errs;
    errs = err_cnt;
    expect_boundary(128, "reset boundary");
    @(posedge clk_sys);
    p1_joy_left <= 1'b1;
    for (int i = 0; i < 3; i++) begin
      pulse_frame();
      digital_pos = digital_model(digital_pos, 1'b1, 1'b0, 1'b0);
    end
    expect_boundary(140, "three slow left steps");
    @(posedge clk_sys);
    p1_joy_left  <= 1'b0;
    p1_joy_right <= 1'b1;
    // More frames than needed to reach the end stop
    for (int i = 0; i < 40; i++) begin
      pulse_frame();
      digital_pos = digital_model(digital_pos, 1'b0, 1'b1, 1'b0);
    end
    expect_boundary(0, "right clamp at zero");
    end_test("reset_digital", errs);
  endtask

  task automatic test_fast_clamp();
    int errs;
    errs = err_cnt;
    @(posedge clk_sys);
    digital_fast <= 1'b1;
    p1_joy_right <= 1'b0;
    p1_joy_left  <= 1'b1;
    for (int i = 0; i < 34; i++) begin
      pulse_frame();
      digital_pos = digital_model(digital_pos, 1'b1, 1'b0, 1'b1);
      if (i == 4) begin
        expect_boundary(digital_pos, "fast left steps");
      end
    end
    expect_boundary(255, "fast left clamp at max");
    @(posedge clk_sys);
    p1_joy_left  <= 1'b0;
    p1_joy_right <= 1'b1;
    pulse_frame();
    digital_pos = digital_model(digital_pos, 1'b0, 1'b1, 1'b1);
    expect_boundary(digital_pos, "fast right step");
    @(posedge clk_sys);
    p1_joy_left <= 1'b1;
    pulse_frame();
    digital_pos = digital_model(digital_pos, 1'b1, 1'b1, 1'b1);
    expect_boundary(digital_pos, "both buttons, left wins");
    @(posedge clk_sys);
    p1_joy_left  <= 1'b0;
    p1_joy_right <= 1'b0;
    digital_fast <= 1'b0;
    end_test("fast_clamp", errs);
  endtask

  task automatic test_spinner();
    int errs;
    logic [7:0] low;
    logic [1:0] spd;
    bit inv;
    errs = err_cnt;
    @(posedge clk_sys);
    p1_mode <= MODE_SPINNER;
    repeat (3) @(posedge clk_sys);
    expect_boundary(spin_pos, "spinner start");
    for (int i = 0; i < 12; i++) begin
      low = $random(seed);
      spd = $random(seed);
      inv = $random(seed);
      @(posedge clk_sys);
      p1_invert  <= inv;
      spin_speed <= spin_speed_e'(spd);
      // Bit 8 toggle marks the increment
      @(posedge clk_sys);
      p1_spinner <= {~p1_spinner[8], low};
      repeat (4) @(posedge clk_sys);
      spin_pos = spinner_model(spin_pos, low, spd, inv);
      expect_boundary(spin_pos, $sformatf("spinner tick %0d", i));
    end
    // Player 1 holds a step of 16 that points away from the nearer end stop
    @(posedge clk_sys);
    p1_invert  <= 1'b0;
    spin_speed <= SPIN_UNSCALED;
    p1_spinner <= {p1_spinner[8], ((spin_pos >= 128) ? 8'h10 : 8'hF0)};
    // Player 2 spinner while player 1 is at the controls
    @(posedge clk_sys);
    p2_spinner <= {~p2_spinner[8], 8'h05};
    repeat (4) @(posedge clk_sys);
    expect_boundary(spin_pos, "inactive spinner ignored");
    end_test("spinner", errs);
  endtask

  task automatic test_analog();
    int errs;
    int sel;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] k;
    logic [7:0] conv;
    logic [7:0] exp;
    bit inv;
    errs = err_cnt;
    for (int i = 0; i < 9; i++) begin
      x = $random(seed);
      y = $random(seed);
      k = $random(seed);
      inv = $random(seed);
      sel = i % 3;
      @(posedge clk_sys);
      p1_stick_x <= x;
      p1_stick_y <= y;
      p1_knob    <= k;
      p1_invert  <= inv;
      // Stick X, stick Y and knob are codes 1 to 3
      p1_mode    <= ctrl_mode_e'(3'(sel + 1));
      repeat (3) @(posedge clk_sys);
      // Sticks move to offset binary and the knob is taken as is
      conv = (sel == 0) ? x ^ 8'h80 : ((sel == 1) ? y ^ 8'h80 : k);
      exp  = inv ? conv : ~conv;
      expect_boundary(exp, $sformatf("analog mode %0d", sel + 1));
    end
    @(posedge clk_sys);
    p1_mode <= ctrl_mode_e'(3'd5);
    repeat (3) @(posedge clk_sys);
    expect_boundary(128, "undefined mode 5");
    @(posedge clk_sys);
    p1_mode <= ctrl_mode_e'(3'd7);
    repeat (3) @(posedge clk_sys);
    expect_boundary(128, "undefined mode 7");
    // Player 2 knob inverted while player 1 is not
    k = $random(seed);
    @(posedge clk_sys);
    player2   <= 1'b1;
    p2_mode   <= MODE_KNOB;
    p2_knob   <= k;
    p2_invert <= 1'b1;
    p1_invert <= 1'b0;
    repeat (3) @(posedge clk_sys);
    expect_boundary(k, "player 2 knob");
    @(posedge clk_sys);
    player2 <= 1'b0;
    end_test("analog", errs);
  endtask

  task automatic test_overlay();
    int errs;
    bit ck;
    bit p2;
    bit hb;
    errs = err_cnt;
    // Upright, cocktail player 2, cocktail player 1
    for (int cfg = 0; cfg < 3; cfg++) begin
      ck = (cfg != 0);
      p2 = (cfg == 1);
      @(posedge clk_sys);
      cocktail <= ck;
      player2  <= p2;
      video    <= 1'b1;
      for (int h = 0; h < 256; h++) begin
        @(posedge clk_sys);
        hcnt <= h;
        vcnt <= h;
        @(posedge clk_sys);
        @(negedge clk_sys);
        hb = (ck && p2) ? (h >= 232 || h <= 32) : (h >= 224 || h <= 24);
        check_value(rgb, expected_color(h, ck), $sformatf("rgb cfg %0d hcnt %0d", cfg, h));
        check_value(hblank, hb, $sformatf("hblank cfg %0d hcnt %0d", cfg, h));
        check_value(vblank, (h >= 228 && h <= 251), $sformatf("vblank vcnt %0d", h));
      end
    end
    // No video means black whatever the band
    for (int i = 0; i < 8; i++) begin
      @(posedge clk_sys);
      video <= 1'b0;
      hcnt  <= $random(seed);
      @(posedge clk_sys);
      @(negedge clk_sys);
      check_value(rgb, 12'h000, "rgb with video low");
    end
    @(posedge clk_sys);
    cocktail <= 1'b0;
    player2  <= 1'b0;
    end_test("overlay", errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_seq
    int n;
    p1_joy_right = 1'b0;
    p1_joy_left  = 1'b0;
    p2_joy_right = 1'b0;
    p2_joy_left  = 1'b0;
    p1_spinner   = '0;
    p2_spinner   = '0;
    p1_stick_x   = '0;
    p1_stick_y   = '0;
    p2_stick_x   = '0;
    p2_stick_y   = '0;
    p1_knob      = '0;
    p2_knob      = '0;
    p1_mode      = MODE_DIGITAL;
    p2_mode      = MODE_DIGITAL;
    p1_invert    = 1'b0;
    p2_invert    = 1'b0;
    digital_fast = 1'b0;
    spin_speed   = SPIN_SHL1;
    player2      = 1'b0;
    cocktail     = 1'b0;
    hsync        = 1'b0;
    vsync        = 1'b0;
    pad_en_n     = 1'b1;
    video        = 1'b0;
    hcnt         = '0;
    vcnt         = '0;
    n = 0;
    while (rst_n !== 1'b1 && n < RESET_LIMIT) begin
      @(posedge clk_sys);
      n++;
    end
    if (rst_n !== 1'b1) begin
      abort_wait("reset release");
    end else begin
      repeat (2) @(posedge clk_sys);
      test_reset_digital();
      test_fast_clamp();
      test_spinner();
      test_analog();
      test_overlay();
      $display("Tests run %0d, tests with errors %0d, failed checks %0d",
               test_cnt, bad_test_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Testbench clock and reset
// 8 ns system clock, reset held low for three cycles
////////////////////////////////////////////////////////////
module tb_clock_gen (
  output logic clk_sys,
  output logic rst_n
);

  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  // Synchronous reset released after the third edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk_sys);
    rst_n <= 1'b1;
  end

endmodule
